//--- compile.f
source/panel_params_pkg.sv
source/panel_types_pkg.sv
source/framebuffer_ram.sv
source/framebuffer_fetch.sv
source/pixel_shifter.sv
source/scan_control.sv
source/hub75_top.sv
dv/tb_clock.sv
dv/hub75_properties.sv
dv/tb_hub75.sv

//--- Makefile
# Verilator build and run of the HUB75 driver testbench

VERILATOR ?= verilator
TOP ?= tb_hub75
FILELIST ?= compile.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VERILATOR_FLAGS ?= --binary --timing --assert
SIM_ARGS ?= +verilator+error+limit+100
PASS_TEXT ?= Done: no errors

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(abspath $(SIM_BIN)) $(SIM_ARGS) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx '$(PASS_TEXT)' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/tb_hub75.sv
/*
 * HUB75 driver testbench, image load over the host handshake,
 * panel monitor against a reference model, timeout and summary
 */
`timescale 1ns/1ps
module tb_hub75;

    localparam int word_count = panel_params_pkg::panel_width * panel_params_pkg::panel_halfheight;
    localparam int column_cycles = 6;
    localparam int write_cycles = word_count * 4;
    // shift, latch and lit time of all planes and scan rows
    localparam int frame_cycles = panel_params_pkg::panel_halfheight *
        (panel_params_pkg::channel_bits * (panel_params_pkg::panel_width * column_cycles + 1) +
         panel_params_pkg::oe_base_cycles * ((1 << panel_params_pkg::channel_bits) - 1));
    localparam int timeout_cycles = (write_cycles + 3 * frame_cycles) * 5 / 4;
    localparam int stall_limit = 16;
    localparam logic [31:0] lfsr_seed = 32'hff287520;
    localparam logic [31:0] lfsr_taps = 32'h80200003;
    // row 2, column 9
    localparam int rewrite_address = 41;

    logic clk_in;
    logic reset;
    logic host_req;
    panel_types_pkg::host_write_t host_write;
    logic host_ack;
    panel_types_pkg::hub75_out_t panel;

    panel_types_pkg::pixel_pair_t image [word_count];

    int errors_reset = 0;
    int errors_write = 0;
    int errors_data = 0;
    int errors_rewrite = 0;
    int errors_order = 0;
    int errors_lit = 0;
    int checks_reset = 0;
    int checks_write = 0;
    int checks_data = 0;
    int checks_rewrite = 0;
    int checks_order = 0;
    int checks_lit = 0;
    // 0 no compare, 1 first full frame, 2 frame after the rewrite
    int data_phase = 0;
    int frames_done = 0;
    int rewrite_hits = 0;
    int cycle_count = 0;

    tb_clock u_clock (
        .clk_in (clk_in),
        .reset (reset)
    );

    hub75_top DUT (
        .clk_in (clk_in),
        .reset (reset),
        .host_req (host_req),
        .host_write (host_write),
        .host_ack (host_ack),
        .panel (panel)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ lfsr_taps;
        end
        return state >> 1;
    endfunction

    // word at row above column with the bottom pixel in the upper half
    function automatic panel_types_pkg::panel_data_t expected_panel_data(
        input logic [1:0] row, input logic [3:0] column, input logic [1:0] plane);
        panel_types_pkg::pixel_pair_t word;
        panel_types_pkg::panel_data_t bits;
        word = image[{row, column}];
        bits.r1 = word.top.red[plane];
        bits.g1 = word.top.green[plane];
        bits.b1 = word.top.blue[plane];
        bits.r2 = word.bottom.red[plane];
        bits.g2 = word.bottom.green[plane];
        bits.b2 = word.bottom.blue[plane];
        return bits;
    endfunction

    // one LFSR step per image bit
    task automatic fill_image();
        logic [31:0] lfsr;
        logic [23:0] bits;
        lfsr = lfsr_seed;
        for (int i = 0; i < word_count; i++) begin
            bits = '0;
            for (int b = 0; b < 24; b++) begin
                bits = {bits[22:0], lfsr[0]};
                lfsr = lfsr_next(lfsr);
            end
            image[6'(i)] = bits;
        end
    endtask

    task automatic check_blanked();
        checks_reset++;
        if (!panel.oe_n || panel.panel_clk || panel.latch) begin
            $display("FAIL %0t: panel not blanked around reset, oe_n %b panel_clk %b latch %b",
                     $time, panel.oe_n, panel.panel_clk, panel.latch);
            errors_reset++;
        end
    endtask

    // four-phase write of one RAM word
    task automatic write_word(input logic [5:0] address,
                              input panel_types_pkg::pixel_pair_t pixels,
                              output logic stalled);
        int waited;
        stalled = 1'b0;
        if (host_ack) begin
            $display("FAIL %0t: host_ack high before req, address %0d", $time, address);
            errors_write++;
        end
        @(posedge clk_in);
        #1;
        host_write.ram_address = address;
        host_write.pixels = pixels;
        host_req = 1'b1;
        waited = 0;
        @(negedge clk_in);
        while (!host_ack && waited < stall_limit) begin
            waited++;
            @(negedge clk_in);
        end
        if (!host_ack) begin
            $display("handshake stalled: no ack for address %0d within %0d cycles",
                     address, stall_limit);
            errors_write++;
            stalled = 1'b1;
            host_req = 1'b0;
        end else begin
            @(posedge clk_in);
            #1;
            if (!host_ack) begin
                $display("FAIL %0t: host_ack fell while req high, address %0d", $time, address);
                errors_write++;
            end
            host_req = 1'b0;
            waited = 0;
            @(negedge clk_in);
            while (host_ack && waited < stall_limit) begin
                waited++;
                @(negedge clk_in);
            end
            if (host_ack) begin
                $display("handshake stalled: ack high %0d cycles after req fell, address %0d",
                         stall_limit, address);
                errors_write++;
                stalled = 1'b1;
            end else begin
                checks_write++;
            end
        end
    endtask

    // samples at the falling edge and tracks row, plane and column from the latches
    initial begin : panel_monitor
        logic prev_clk;
        logic prev_oe_n;
        logic [1:0] exp_row;
        logic [1:0] exp_plane;
        logic [1:0] lit_plane;
        int shift_count;
        int lit_count;
        int lit_expected;
        panel_types_pkg::panel_data_t expected;
        prev_clk = 1'b0;
        prev_oe_n = 1'b1;
        exp_row = 2'd0;
        exp_plane = 2'd0;
        lit_plane = 2'd0;
        shift_count = 0;
        lit_count = 0;
        lit_expected = 0;
        forever begin
            @(negedge clk_in);
            if (reset) begin
                shift_count = 0;
                exp_row = 2'd0;
                exp_plane = 2'd0;
            end else begin
                if (panel.panel_clk && !prev_clk) begin
                    if (data_phase != 0 && shift_count < panel_params_pkg::panel_width) begin
                        expected = expected_panel_data(exp_row, 4'(shift_count), exp_plane);
                        if (panel.data !== expected) begin
                            $display("FAIL %0t: row %0d column %0d plane %0d data %b expected %b",
                                     $time, exp_row, shift_count, exp_plane, panel.data, expected);
                            if (data_phase == 1) begin
                                errors_data++;
                            end else begin
                                errors_rewrite++;
                            end
                        end
                        if (data_phase == 1) begin
                            checks_data++;
                        end else begin
                            checks_rewrite++;
                            if ({exp_row, 4'(shift_count)} == 6'(rewrite_address)) begin
                                rewrite_hits++;
                            end
                        end
                    end
                    shift_count++;
                end
                if (panel.latch) begin
                    checks_order++;
                    if (shift_count != panel_params_pkg::panel_width ||
                        panel.row_address != exp_row) begin
                        $display("FAIL %0t: latch on row %0d after %0d columns, expected row %0d",
                                 $time, panel.row_address, shift_count, exp_row);
                        errors_order++;
                    end
                    lit_plane = exp_plane;
                    lit_count = 0;
                    shift_count = 0;
                    if (exp_plane == 2'd3) begin
                        if (exp_row == 2'd3) begin
                            frames_done++;
                        end
                        exp_row = exp_row + 2'd1;
                    end
                    exp_plane = exp_plane + 2'd1;
                end
                if (!panel.oe_n) begin
                    lit_count++;
                end
                if (panel.oe_n && !prev_oe_n) begin
                    checks_lit++;
                    lit_expected = panel_params_pkg::oe_base_cycles << lit_plane;
                    if (lit_count != lit_expected) begin
                        $display("FAIL %0t: plane %0d lit for %0d cycles, expected %0d",
                                 $time, lit_plane, lit_count, lit_expected);
                        errors_lit++;
                    end
                end
            end
            prev_clk = panel.panel_clk;
            prev_oe_n = panel.oe_n;
        end
    end

    initial begin : watchdog
        while (cycle_count < timeout_cycles) begin
            @(posedge clk_in);
            cycle_count++;
        end
        $display("timeout: the run did not finish within %0d clock cycles", timeout_cycles);
        $display("Done: errors found");
        $finish;
    end

    initial begin : main_sequence
        logic stalled;
        int frame_mark;
        int rewrite_miss;
        int total_errors;
        int total_checks;
        panel_types_pkg::pixel_pair_t new_word;
        host_req = 1'b0;
        host_write = '0;
        stalled = 1'b0;
        rewrite_miss = 0;
        fill_image();

        @(posedge clk_in);
        @(negedge clk_in);
        while (reset) begin
            check_blanked();
            @(negedge clk_in);
        end
        check_blanked();
        @(negedge clk_in);
        check_blanked();
        $display("test reset_state: %0d checks, %0d errors", checks_reset, errors_reset);

        for (int i = 0; i < word_count && !stalled; i++) begin
            write_word(6'(i), image[6'(i)], stalled);
        end
        $display("test write_handshake: %0d writes, %0d errors", checks_write, errors_write);

        if (!stalled) begin
            // first frame whose fetches all follow the image load
            frame_mark = frames_done;
            wait (frames_done > frame_mark);
            data_phase = 1;
            wait (frames_done > frame_mark + 1);
            $display("test shifted_data: %0d checks, %0d errors", checks_data, errors_data);

            // lands in the lit time of row 3 plane 3 ahead of the next fetch
            data_phase = 2;
            new_word = ~image[6'(rewrite_address)];
            write_word(6'(rewrite_address), new_word, stalled);
            image[6'(rewrite_address)] = new_word;
            wait (frames_done > frame_mark + 2);
            data_phase = 0;
            if (rewrite_hits != panel_params_pkg::channel_bits) begin
                $display("the rewritten column was shifted %0d times in the frame, expected %0d",
                         rewrite_hits, panel_params_pkg::channel_bits);
                rewrite_miss = 1;
            end
            $display("test live_rewrite: %0d checks, %0d errors",
                     checks_rewrite, errors_rewrite + rewrite_miss);
        end
        $display("test scan_order: %0d latches, %0d errors", checks_order, errors_order);
        $display("test lit_time: %0d checks, %0d errors", checks_lit, errors_lit);

        total_checks = checks_reset + checks_write + checks_data + checks_rewrite +
                       checks_order + checks_lit;
        total_errors = errors_reset + errors_write + errors_data + errors_rewrite +
                       rewrite_miss + errors_order + errors_lit +
                       DUT.u_properties.assertion_failures;
        $display("summary: %0d checks, %0d errors, %0d assertion failures, %0d cycles",
                 total_checks, total_errors, DUT.u_properties.assertion_failures, cycle_count);
        if (total_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- dv/hub75_properties.sv
/*
 * concurrent checks on the host handshake and panel control lines,
 * bound into the driver top next to the scan controller and RAM
 */
`timescale 1ns/1ps
module hub75_properties (
    input logic clk_in,
    input logic reset,
    input logic host_req,
    input logic host_ack,
    input logic latch,
    input logic oe_n,
    input logic panel_clk,
    input logic [panel_params_pkg::row_bits-1:0] row_address
);

    // failed assertion count
    int assertion_failures = 0;

    // ack stays up until the host drops req
    ack_held: assert property (@(posedge clk_in) disable iff (reset)
        host_req && host_ack |=> host_ack)
        else begin
            $error("host_ack fell while host_req was high");
            assertion_failures++;
        end

    latch_blanked: assert property (@(posedge clk_in) disable iff (reset)
        latch |-> oe_n)
        else begin
            $error("latch pulsed while the row was lit");
            assertion_failures++;
        end

    // no shifting into a lit row
    clock_blanked: assert property (@(posedge clk_in) disable iff (reset)
        panel_clk |-> oe_n)
        else begin
            $error("panel_clk high while oe_n was low");
            assertion_failures++;
        end

    row_held: assert property (@(posedge clk_in) disable iff (reset)
        !oe_n |=> $stable(row_address))
        else begin
            $error("row address moved while the row was lit");
            assertion_failures++;
        end

endmodule

bind hub75_top hub75_properties u_properties (
    .clk_in (clk_in),
    .reset (reset),
    .host_req (host_req),
    .host_ack (host_ack),
    .latch (latch),
    .oe_n (oe_n),
    .panel_clk (panel_clk),
    .row_address (row_address)
);

//--- dv/tb_clock.sv
/*
 * testbench clock, 20 ns period, and power-on reset
 */
`timescale 1ns/1ps
module tb_clock (
    output logic clk_in,
    output logic reset
);

    initial begin
        clk_in = 1'b0;
        forever #10 clk_in = ~clk_in;
    end

    // held for 5 rising edges, released just after the last one
    initial begin
        reset = 1'b1;
        repeat (5) @(posedge clk_in);
        #1 reset = 1'b0;
    end

endmodule

//--- source/hub75_top.sv
/*
 * HUB75 panel driver top, scan controller with framebuffer
 * RAM, fetch and pixel shifter
 */
`timescale 1ns/1ps
module hub75_top (
    input logic clk_in,
    input logic reset,

    input logic host_req,
    input panel_types_pkg::host_write_t host_write,
    output logic host_ack,

    output panel_types_pkg::hub75_out_t panel
);

    logic [panel_params_pkg::column_bits-1:0] column_address;
    logic [panel_params_pkg::row_bits-1:0] row_address;
    logic [1:0] bit_plane;
    logic pixel_load_start;
    logic pixel_ready;
    logic shift_done;
    logic latch;
    logic oe_n;

    logic [panel_params_pkg::ram_address_bits-1:0] ram_address;
    logic ram_clk_enable;
    panel_types_pkg::pixel_pair_t ram_data;
    panel_types_pkg::pixel_pair_t pixel_pair;

    panel_types_pkg::panel_data_t panel_data;
    logic panel_clk;

    scan_control u_scan_control (
        .clk_in (clk_in),
        .reset (reset),
        .pixel_ready (pixel_ready),
        .shift_done (shift_done),
        .column_address (column_address),
        .row_address (row_address),
        .bit_plane (bit_plane),
        .pixel_load_start (pixel_load_start),
        .latch (latch),
        .oe_n (oe_n)
    );

    framebuffer_ram u_framebuffer_ram (
        .clk_in (clk_in),
        .reset (reset),
        .host_req (host_req),
        .host_write (host_write),
        .host_ack (host_ack),
        .ram_address (ram_address),
        .ram_clk_enable (ram_clk_enable),
        .ram_data (ram_data)
    );

    framebuffer_fetch u_framebuffer_fetch (
        .clk_in (clk_in),
        .reset (reset),
        .column_address (column_address),
        .row_address (row_address),
        .pixel_load_start (pixel_load_start),
        .ram_data (ram_data),
        .ram_address (ram_address),
        .ram_clk_enable (ram_clk_enable),
        .pixel_pair (pixel_pair),
        .pixel_ready (pixel_ready)
    );

    pixel_shifter u_pixel_shifter (
        .clk_in (clk_in),
        .reset (reset),
        .pixel_ready (pixel_ready),
        .pixel_pair (pixel_pair),
        .bit_plane (bit_plane),
        .panel_data (panel_data),
        .panel_clk (panel_clk),
        .shift_done (shift_done)
    );

    // connector pins
    assign panel = '{
        data: panel_data,
        panel_clk: panel_clk,
        latch: latch,
        oe_n: oe_n,
        row_address: row_address
    };

endmodule

//--- source/scan_control.sv
/*
 * scan sequencer over columns, bit planes and rows,
 * drives fetch start, latch, output enable and row address
 */
`timescale 1ns/1ps
module scan_control (
    input logic clk_in,
    input logic reset,

    input logic pixel_ready,
    input logic shift_done,

    output logic [panel_params_pkg::column_bits-1:0] column_address,
    output logic [panel_params_pkg::row_bits-1:0] row_address,
    output logic [1:0] bit_plane,
    output logic pixel_load_start,
    output logic latch,
    output logic oe_n
);

    typedef enum logic [2:0] {
        st_fetch,
        st_wait_fetch,
        st_wait_shift,
        st_latch,
        st_display,
        st_advance
    } scan_state_t;

    // sized for the longest lit time, the highest plane
    typedef logic [$clog2(panel_params_pkg::oe_base_cycles <<
                          (panel_params_pkg::channel_bits - 1))-1:0] display_count_t;

    scan_state_t state;
    display_count_t display_count;

    logic last_column;
    logic last_plane;
    logic last_row;

    assign last_column = (int'(column_address) == panel_params_pkg::panel_width - 1);
    assign last_plane = (int'(bit_plane) == panel_params_pkg::channel_bits - 1);
    assign last_row = (int'(row_address) == panel_params_pkg::panel_halfheight - 1);

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state <= st_fetch;
            column_address <= '0;
            row_address <= '0;
            bit_plane <= 2'd0;
            display_count <= '0;
            pixel_load_start <= 1'b0;
            latch <= 1'b0;
            oe_n <= 1'b1;
        end else begin
            pixel_load_start <= 1'b0;
            latch <= 1'b0;
            case (state)
                st_fetch: begin
                    // first column after reset
                    pixel_load_start <= 1'b1;
                    state <= st_wait_fetch;
                end
                st_wait_fetch: begin
                    if (pixel_ready) begin
                        state <= st_wait_shift;
                    end
                end
                st_wait_shift: begin
                    if (shift_done) begin
                        if (last_column) begin
                            latch <= 1'b1;
                            state <= st_latch;
                        end else begin
                            // start the next column right away
                            column_address <= column_address + 1'b1;
                            pixel_load_start <= 1'b1;
                            state <= st_wait_fetch;
                        end
                    end
                end
                st_latch: begin
                    // light the row, weighted by plane
                    oe_n <= 1'b0;
                    display_count <= display_count_t'(
                        (panel_params_pkg::oe_base_cycles << bit_plane) - 1);
                    state <= st_display;
                end
                st_display: begin
                    if (display_count == '0) begin
                        oe_n <= 1'b1;
                        state <= st_advance;
                    end else begin
                        display_count <= display_count - 1'b1;
                    end
                end
                st_advance: begin
                    // blanked here, safe to move the row
                    if (last_plane) begin
                        bit_plane <= 2'd0;
                        if (last_row) begin
                            row_address <= '0;
                        end else begin
                            row_address <= row_address + 1'b1;
                        end
                    end else begin
                        bit_plane <= bit_plane + 1'b1;
                    end
                    column_address <= '0;
                    pixel_load_start <= 1'b1;
                    state <= st_wait_fetch;
                end
                default: begin
                    state <= st_fetch;
                end
            endcase
        end
    end

endmodule

//--- source/pixel_shifter.sv
/*
 * bit plane select of the top/bottom pixel pair and
 * one panel clock pulse per column
 */
`timescale 1ns/1ps
module pixel_shifter (
    input logic clk_in,
    input logic reset,

    input logic pixel_ready,
    input panel_types_pkg::pixel_pair_t pixel_pair,
    input logic [1:0] bit_plane,

    output panel_types_pkg::panel_data_t panel_data,
    output logic panel_clk,
    output logic shift_done
);

    typedef enum logic [1:0] {
        st_idle,
        st_setup,
        st_clock
    } shift_state_t;

    shift_state_t state;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state <= st_idle;
            panel_data <= '0;
            panel_clk <= 1'b0;
            shift_done <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (pixel_ready) begin
                        // current plane bit of every channel
                        panel_data.r1 <= pixel_pair.top.red[bit_plane];
                        panel_data.g1 <= pixel_pair.top.green[bit_plane];
                        panel_data.b1 <= pixel_pair.top.blue[bit_plane];
                        panel_data.r2 <= pixel_pair.bottom.red[bit_plane];
                        panel_data.g2 <= pixel_pair.bottom.green[bit_plane];
                        panel_data.b2 <= pixel_pair.bottom.blue[bit_plane];
                        state <= st_setup;
                    end
                end
                st_setup: begin
                    // data has had a full cycle of setup before the rising edge
                    panel_clk <= 1'b1;
                    // done flags the clock cycle so the next fetch follows directly
                    shift_done <= 1'b1;
                    state <= st_clock;
                end
                st_clock: begin
                    panel_clk <= 1'b0;
                    shift_done <= 1'b0;
                    state <= st_idle;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

endmodule

//--- source/framebuffer_fetch.sv
/*
 * timed RAM read of one pixel pair per column,
 * capture of the top/bottom pair and ready pulse
 */
`timescale 1ns/1ps
module framebuffer_fetch (
    input logic clk_in,
    input logic reset,

    input logic [panel_params_pkg::column_bits-1:0] column_address,
    input logic [panel_params_pkg::row_bits-1:0] row_address,
    input logic pixel_load_start,

    // RAM read port
    input panel_types_pkg::pixel_pair_t ram_data,
    output logic [panel_params_pkg::ram_address_bits-1:0] ram_address,
    output logic ram_clk_enable,

    output panel_types_pkg::pixel_pair_t pixel_pair,
    output logic pixel_ready
);

    // counts down through the read window, zero when idle
    logic [1:0] window_count;

    // address is held steady by the controller for the whole window
    assign ram_address = {row_address, column_address};

    assign ram_clk_enable = (window_count != 2'd0);

    always_ff @(posedge clk_in) begin
        if (reset) begin
            window_count <= 2'd0;
        end else begin
            if (pixel_load_start) begin
                window_count <= 2'(panel_params_pkg::fetch_cycles);
            end else if (window_count != 2'd0) begin
                window_count <= window_count - 1'b1;
            end
        end
    end

    // ready goes high together with the captured pair
    always_ff @(posedge clk_in) begin
        if (reset) begin
            pixel_ready <= 1'b0;
        end else begin
            pixel_ready <= (window_count == 2'(panel_params_pkg::capture_count));
        end
    end

    // registered read data is valid at this point of the window
    always_ff @(posedge clk_in) begin
        if (window_count == 2'(panel_params_pkg::capture_count)) begin
            pixel_pair <= ram_data;
        end
    end

endmodule

//--- source/framebuffer_ram.sv
/*
 * framebuffer memory, host write port with req/ack handshake,
 * clock-enabled registered read port for the scan side
 */
`timescale 1ns/1ps
module framebuffer_ram (
    input logic clk_in,
    input logic reset,

    // host side
    input logic host_req,
    input panel_types_pkg::host_write_t host_write,
    output logic host_ack,

    // scan side
    input logic [panel_params_pkg::ram_address_bits-1:0] ram_address,
    input logic ram_clk_enable,
    output panel_types_pkg::pixel_pair_t ram_data
);

    // one word per column and scan row
    panel_types_pkg::pixel_pair_t mem [panel_params_pkg::panel_width *
                                       panel_params_pkg::panel_halfheight];

    // write port and ack state
    always_ff @(posedge clk_in) begin
        if (reset) begin
            host_ack <= 1'b0;
        end else begin
            if (host_req && !host_ack) begin
                // new request, write once and acknowledge
                mem[host_write.ram_address] <= host_write.pixels;
                host_ack <= 1'b1;
            end else if (!host_req && host_ack) begin
                host_ack <= 1'b0;
            end
        end
    end

    // read port, data one cycle after the enabled read
    always_ff @(posedge clk_in) begin
        if (ram_clk_enable) begin
            ram_data <= mem[ram_address];
        end
    end

endmodule

//--- source/panel_types_pkg.sv
/*
 * pixel, RAM word, host write and panel output structs
 */
package panel_types_pkg;

    // one pixel, 4 bits per channel
    typedef struct packed {
        logic [panel_params_pkg::channel_bits-1:0] red;
        logic [panel_params_pkg::channel_bits-1:0] green;
        logic [panel_params_pkg::channel_bits-1:0] blue;
    } rgb_pixel_t;

    // one RAM word, bottom half pixel in the upper bits
    typedef struct packed {
        rgb_pixel_t bottom;
        rgb_pixel_t top;
    } pixel_pair_t;

    // host write payload, held stable while req is high
    typedef struct packed {
        logic [panel_params_pkg::ram_address_bits-1:0] ram_address;
        pixel_pair_t pixels;
    } host_write_t;

    // HUB75 colour lines, 1 for top half and 2 for bottom half
    typedef struct packed {
        logic r1;
        logic g1;
        logic b1;
        logic r2;
        logic g2;
        logic b2;
    } panel_data_t;

    // everything that goes to the panel connector
    typedef struct packed {
        panel_data_t data;
        logic panel_clk;
        logic latch;
        logic oe_n;
        logic [panel_params_pkg::row_bits-1:0] row_address;
    } hub75_out_t;

endpackage

//--- source/panel_params_pkg.sv
/*
 * panel geometry, bit plane count and scan timing constants
 */
package panel_params_pkg;

    // panel geometry, top and bottom halves are scanned together
    localparam int panel_width = 16;
    localparam int panel_height = 8;
    localparam int panel_halfheight = 4;

    // colour depth, also the number of bit planes
    localparam int channel_bits = 4;

    // address widths
    localparam int column_bits = 4;
    localparam int row_bits = 2;
    // row sits above column in the RAM address
    localparam int ram_address_bits = 6;

    // lit time of plane 0, doubles for each higher plane
    localparam int oe_base_cycles = 8;

    // framebuffer fetch window
    localparam int fetch_cycles = 3;
    // window count at which the read word is valid
    localparam int capture_count = 2;

endpackage
